// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - verilog/isa_pkg.sv
  - verilog/fetch_pkg.sv
  - verilog/pc_gen.sv
  - verilog/imem_req.sv
  - verilog/stage_reg.sv
  - verilog/ctrl_decode.sv
  - verilog/fetch_top.sv
  - target: simulation
    files:
      - sim/fetch_checker.sv
      - sim/tb_fetch.sv

// ==== sim/fetch_cases.txt ====
# mem <addr> <word> : instruction image in hex, unlisted words use the fill pattern
# test <name> <con_b> <addr_jr> <count> <pc ...> : expected delivery order after reset
mem 0 20010001
mem 4 20020002
mem 8 20030003
mem c 08000010
mem 40 20040004
mem 44 0c000020
mem 80 20050005
mem 84 1000001e
mem 88 20060006
mem 8c 03e00008
mem 100 20070007
mem 104 1000ffde
# straight line, then j, jal, beq not taken and jr out of the image
test straight 0 0 3 0 4 8
test jr_far 0 200 12 0 4 8 c 40 44 80 84 88 8c 200 204
# beq taken forward and backward
test beq_taken 1 0 13 0 4 8 c 40 44 80 84 100 104 80 84 100
# jr back to the start of the program
test jr_loop 0 0 14 0 4 8 c 40 44 80 84 88 8c 0 4 8 c

// ==== sim/fetch_checker.sv ====
/*
 * output port monitor: reference memory image, expected PCs,
 * packet comparison and error counts
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_checker
	import isa_pkg::*, fetch_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_nrst,
	input  logic     i_req,
	input  logic     i_ack,
	input  dec_pkt_t i_pkt
);

	// image covers the first 1 KiB and everything else reads as fill
	instr_t          image [256];
	bit              loaded [256];
	logic [31:0]     exp_pc [256];
	logic [8*16-1:0] test_name;
	int              exp_count;
	int              got;
	int              value_errs = 0;

	// ==============================
	// reference data
	// ==============================
	function automatic instr_t word_at(input logic [31:0] addr);
		if (addr < 32'd1024 && loaded[addr[9:2]]) begin
			return image[addr[9:2]];
		end
		// addi opcode so the fill never transfers control
		// every address bit reaches the low field
		return {6'h08, addr[25:0] ^ {addr[31:26], 20'h0}};
	endfunction

	// transfer class straight from the opcode and funct fields
	function automatic xfer_kind_e expected_kind(input instr_t w);
		xfer_kind_e k;
		k = KIND_SEQ;
		if (w[31:26] == OP_J || w[31:26] == OP_JAL) begin
			k = KIND_JUMP;
		end else if (w[31:26] == OP_BEQ) begin
			k = KIND_BRANCH;
		end else if (w[31:26] == OP_RTYPE && w[5:0] == FN_JR) begin
			k = KIND_JREG;
		end
		return k;
	endfunction

	task automatic set_word(input logic [31:0] addr, input instr_t w);
		image[addr[9:2]] = w;
		loaded[addr[9:2]] = 1'b1;
	endtask

	task automatic start_test(input logic [8*16-1:0] name, input int count);
		test_name = name;
		exp_count = count;
	endtask

	task automatic set_expect(input int idx, input logic [31:0] pc);
		exp_pc[idx] = pc;
	endtask

	task automatic compare(input logic [8*8-1:0] field, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %0s %0s: expected %h, got %h", test_name, field, exp, act);
			value_errs++;
		end
	endtask

	// ==============================
	// output transfers
	// ==============================
	// req and ack both high for exactly one edge per packet
	// only the listed prefix of the packet stream is compared
	always @(posedge i_clk) begin
		if (!i_nrst) begin
			got <= 0;
		end else if (i_req && i_ack && got < exp_count) begin
			compare("pc", exp_pc[got], i_pkt.pc);
			compare("instr", word_at(exp_pc[got]), i_pkt.instr);
			compare("pc4", exp_pc[got] + 32'd4, i_pkt.pc4);
			compare("kind", 32'(expected_kind(word_at(exp_pc[got]))), 32'(i_pkt.kind));
			got <= got + 1;
		end
	end

endmodule

`default_nettype wire

// ==== sim/tb_fetch.sv ====
/*
 * testbench for the fetch front end: clock, reset, memory and
 * consumer models, case file sequencing, timeout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch
	import isa_pkg::*, fetch_pkg::*;
();

	logic        clk;
	logic        nrst;
	logic        con_b;
	logic [31:0] addr_jr;
	logic        mem_req;
	logic [31:0] mem_addr;
	logic        mem_ack;
	instr_t      mem_rdata;
	logic        req;
	logic        ack;
	dec_pkt_t    pkt;

	// tests parsed from the case file
	logic [8*16-1:0] names [8];
	int              conbs [8];
	logic [31:0]     jr_targets [8];
	int              counts [8];
	int              firsts [8];
	logic [31:0]     pcs [256];
	int              ntests;
	int              npcs;
	int              limit;
	int              cycles;
	int              tb_errs;
	int              seed;

	fetch_top DUT (
		.i_clk       (clk),
		.i_nrst      (nrst),
		.i_con_b     (con_b),
		.i_addr_jr   (addr_jr),
		.o_mem_req   (mem_req),
		.o_mem_addr  (mem_addr),
		.i_mem_ack   (mem_ack),
		.i_mem_rdata (mem_rdata),
		.o_req       (req),
		.i_ack       (ack),
		.o_pkt       (pkt)
	);

	fetch_checker u_checker (
		.i_clk  (clk),
		.i_nrst (nrst),
		.i_req  (req),
		.i_ack  (ack),
		.i_pkt  (pkt)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// ==============================
	// memory and consumer models
	// ==============================
	always begin
		@(posedge clk);
		if (mem_req) begin
			repeat ($urandom % 4) @(posedge clk);
			#2;
			mem_rdata = u_checker.word_at(mem_addr);
			mem_ack = 1'b1;
			do @(posedge clk); while (mem_req);
			repeat ($urandom % 4) @(posedge clk);
			#2;
			mem_ack = 1'b0;
		end
	end

	// random ack delays give the back-pressure
	always begin
		@(posedge clk);
		if (req) begin
			repeat ($urandom % 4) @(posedge clk);
			#2;
			ack = 1'b1;
			do @(posedge clk); while (req);
			repeat ($urandom % 4) @(posedge clk);
			#2;
			ack = 1'b0;
		end
	end

	// ==============================
	// case file and sequencing
	// ==============================
	task automatic read_cases();
		int              fd;
		int              n;
		int              i;
		int              cnt;
		int              cb;
		logic [8*16-1:0] tag;
		logic [8*16-1:0] name;
		logic [31:0]     addr;
		logic [31:0]     word;
		logic [8*128-1:0] rest;
		ntests = 0;
		npcs = 0;
		fd = $fopen("sim/fetch_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file sim/fetch_cases.txt");
			tb_errs++;
			return;
		end
		while ($fscanf(fd, " %s", tag) == 1) begin
			if (tag == "mem") begin
				n = $fscanf(fd, " %h %h", addr, word);
				u_checker.set_word(addr, word);
			end else if (tag == "test") begin
				n = $fscanf(fd, " %s %d %h %d", name, cb, addr, cnt);
				names[ntests] = name;
				conbs[ntests] = cb;
				jr_targets[ntests] = addr;
				counts[ntests] = cnt;
				firsts[ntests] = npcs;
				for (i = 0; i < cnt; i++) begin
					n = $fscanf(fd, " %h", addr);
					pcs[npcs] = addr;
					npcs++;
				end
				ntests++;
			end else begin
				// comment lines are skipped to their end
				n = $fgets(rest, fd);
			end
		end
		$fclose(fd);
	endtask

	task automatic run_test(input int t);
		int i;
		@(posedge clk);
		#2;
		nrst = 1'b0;
		con_b = (conbs[t] != 0);
		addr_jr = jr_targets[t];
		u_checker.start_test(names[t], counts[t]);
		for (i = 0; i < counts[t]; i++) begin
			u_checker.set_expect(i, pcs[firsts[t] + i]);
		end
		repeat (16) @(posedge clk);
		#2;
		nrst = 1'b1;
		while (u_checker.got < counts[t]) begin
			@(posedge clk);
		end
	endtask

	task automatic report_counts();
		$display("errors: %0d value, %0d other", u_checker.value_errs, tb_errs);
	endtask

	initial begin
		int t;
		int total;
		nrst = 1'b0;
		con_b = 1'b0;
		addr_jr = 32'h0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		ack = 1'b0;
		tb_errs = 0;
		cycles = 0;
		seed = 34;
		void'($urandom(seed));
		read_cases();
		if (ntests == 0) begin
			$display("no tests found in the case file");
			tb_errs++;
		end
		total = 0;
		for (t = 0; t < ntests; t++) begin
			total += counts[t];
		end
		// 40 cycles per packet plus 16 reset cycles per test
		limit = total * 40 + ntests * 16;
		for (t = 0; t < ntests; t++) begin
			run_test(t);
		end
		report_counts();
		if (u_checker.value_errs + tb_errs == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			#1;
			$display("timeout: the run did not finish within %0d cycles", limit);
			tb_errs++;
			report_counts();
			$display("sim failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ctrl_decode.sv ====
/*
 * control transfer decode: kind, jump and branch targets, redirect
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_decode
	import isa_pkg::*, fetch_pkg::*;
(
	input  logic        i_valid,
	input  fetch_word_t i_word,
	input  logic        i_con_b,
	input  logic [31:0] i_addr_jr,
	output dec_pkt_t    o_pkt,
	output redirect_t   o_redirect
);

	logic [OP_W-1:0]    opcode;
	logic [FN_W-1:0]    funct;
	logic [IDX_W-1:0]   index;
	logic [IMM_W-1:0]   imm;
	logic [31:0]        jump_target;
	logic [31:0]        branch_target;
	xfer_kind_e         kind;
	logic               taken;
	logic [31:0]        target;

	// ==============================
	// fields and targets
	// ==============================
	assign opcode = i_word.instr[OP_LSB +: OP_W];
	assign funct  = i_word.instr[FN_W-1:0];
	assign index  = i_word.instr[IDX_W-1:0];
	assign imm    = i_word.instr[IMM_W-1:0];

	// region bits of pc4 over the word index
	assign jump_target = {i_word.pc4[INSTR_W-1 -: INSTR_W-IDX_W-2], index, 2'b00};

	// signed word offset from pc4
	assign branch_target = i_word.pc4 +
		{{(INSTR_W-IMM_W-2){imm[IMM_W-1]}}, imm, 2'b00};

	// ==============================
	// classify
	// ==============================
	always_comb begin
		kind   = KIND_SEQ;
		taken  = 1'b0;
		target = branch_target;
		if (opcode == OP_J || opcode == OP_JAL) begin
			kind   = KIND_JUMP;
			taken  = 1'b1;
			target = jump_target;
		end else if (opcode == OP_BEQ) begin
			// not taken stays a branch, just no redirect
			kind  = KIND_BRANCH;
			taken = i_con_b;
		end else if (opcode == OP_RTYPE && funct == FN_JR) begin
			kind   = KIND_JREG;
			taken  = 1'b1;
			target = i_addr_jr;
		end
	end

	assign o_pkt.pc    = i_word.pc;
	assign o_pkt.pc4   = i_word.pc4;
	assign o_pkt.instr = i_word.instr;
	assign o_pkt.kind  = kind;

	assign o_redirect.valid  = i_valid && taken;
	assign o_redirect.target = target;

endmodule

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
/*
 * fetch pipeline payloads: fetched word, transfer kind,
 * decoded packet and PC redirect
 */
`default_nettype none

package fetch_pkg;

	import isa_pkg::*;

	// ==============================
	// IF/ID payload
	// ==============================
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] pc4;
		instr_t      instr;
	} fetch_word_t;

	// ==============================
	// decode results
	// ==============================
	// control transfer class of one instruction
	typedef enum logic [1:0] {
		KIND_SEQ,
		KIND_JUMP,
		KIND_BRANCH,
		KIND_JREG
	} xfer_kind_e;

	// what leaves on the output port
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] pc4;
		instr_t      instr;
		xfer_kind_e  kind;
	} dec_pkt_t;

	// decode back to the PC register
	typedef struct packed {
		logic        valid;
		logic [31:0] target;
	} redirect_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_top.sv ====
/*
 * fetch front end: PC, memory requester, IF/ID, decode, output port
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
	import isa_pkg::*, fetch_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_nrst,
	input  logic        i_con_b,
	input  logic [31:0] i_addr_jr,
	output logic        o_mem_req,
	output logic [31:0] o_mem_addr,
	input  logic        i_mem_ack,
	input  instr_t      i_mem_rdata,
	output logic        o_req,
	input  logic        i_ack,
	output dec_pkt_t    o_pkt
);

	typedef enum logic [1:0] {
		O_IDLE,
		O_REQ,
		O_REL
	} out_state_e;

	logic [31:0] pc;
	logic [31:0] pc4;
	logic        fetch_done;
	fetch_word_t fetch_word;
	logic        ifid_valid;
	fetch_word_t ifid_word;
	dec_pkt_t    dec_pkt;
	redirect_t   redirect;
	logic        out_valid;
	out_state_e  out_state;
	logic        out_drain;
	logic        out_ready;
	logic        ifid_move;
	logic        ifid_hold;
	logic        out_hold;

	// ==============================
	// flow control
	// ==============================
	// output slot frees up on the ack fall
	assign out_drain = (out_state == O_REL) && !i_ack;
	assign out_ready = !out_valid || out_drain;
	assign ifid_move = ifid_valid && out_ready;
	assign ifid_hold = ifid_valid && !out_ready;
	assign out_hold  = out_valid && !out_drain;

	// ==============================
	// stages
	// ==============================
	pc_gen u_pc_gen (
		.i_clk      (i_clk),
		.i_nrst     (i_nrst),
		.i_advance  (fetch_done),
		.i_redirect (redirect),
		.o_pc       (pc),
		.o_pc4      (pc4)
	);

	imem_req u_imem_req (
		.i_clk       (i_clk),
		.i_nrst      (i_nrst),
		.i_pc        (pc),
		.i_pc4       (pc4),
		.i_stall     (!out_ready),
		.i_kill      (redirect.valid),
		.o_mem_req   (o_mem_req),
		.o_mem_addr  (o_mem_addr),
		.i_mem_ack   (i_mem_ack),
		.i_mem_rdata (i_mem_rdata),
		.o_done      (fetch_done),
		.o_word      (fetch_word)
	);

	// younger word is squashed by a taken transfer
	stage_reg #(.payload_t(fetch_word_t)) u_ifid (
		.i_clk   (i_clk),
		.i_nrst  (i_nrst),
		.i_load  (fetch_done),
		.i_hold  (ifid_hold),
		.i_flush (redirect.valid),
		.i_data  (fetch_word),
		.o_valid (ifid_valid),
		.o_data  (ifid_word)
	);

	// redirect only fires as the transfer itself moves on
	ctrl_decode u_ctrl_decode (
		.i_valid    (ifid_move),
		.i_word     (ifid_word),
		.i_con_b    (i_con_b),
		.i_addr_jr  (i_addr_jr),
		.o_pkt      (dec_pkt),
		.o_redirect (redirect)
	);

	stage_reg #(.payload_t(dec_pkt_t)) u_out (
		.i_clk   (i_clk),
		.i_nrst  (i_nrst),
		.i_load  (ifid_move),
		.i_hold  (out_hold),
		.i_flush (1'b0),
		.i_data  (dec_pkt),
		.o_valid (out_valid),
		.o_data  (o_pkt)
	);

	// ==============================
	// output handshake
	// ==============================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			out_state <= O_IDLE;
		end else begin
			case (out_state)
				O_IDLE: begin
					if (out_valid) begin
						out_state <= O_REQ;
					end
				end
				O_REQ: begin
					if (i_ack) begin
						out_state <= O_REL;
					end
				end
				O_REL: begin
					if (!i_ack) begin
						out_state <= O_IDLE;
					end
				end
				default: begin
					out_state <= O_IDLE;
				end
			endcase
		end
	end

	assign o_req = (out_state == O_REQ);

endmodule

`default_nettype wire

// ==== verilog/imem_req.sv ====
/*
 * four-phase requester to the instruction memory, one fetch per PC
 */
`timescale 1ns/1ps
`default_nettype none

module imem_req
	import isa_pkg::*, fetch_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_nrst,
	input  logic [31:0] i_pc,
	input  logic [31:0] i_pc4,
	input  logic        i_stall,
	input  logic        i_kill,
	output logic        o_mem_req,
	output logic [31:0] o_mem_addr,
	input  logic        i_mem_ack,
	input  instr_t      i_mem_rdata,
	output logic        o_done,
	output fetch_word_t o_word
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT_ACK,
		S_WAIT_REL,
		S_DONE
	} state_e;

	state_e      state;
	logic        stale;
	logic        issue;
	fetch_word_t word_q;

	// start a fetch only when downstream has room and no redirect is pending
	assign issue = (state == S_IDLE) && !i_stall && !i_kill;

	// ==============================
	// handshake FSM
	// ==============================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			state <= S_IDLE;
			stale <= 1'b0;
		end else begin
			// a redirect while busy makes the returning word useless
			if (state != S_IDLE && i_kill) begin
				stale <= 1'b1;
			end
			case (state)
				S_IDLE: begin
					if (issue) begin
						state <= S_WAIT_ACK;
						stale <= 1'b0;
					end
				end
				S_WAIT_ACK: begin
					if (i_mem_ack) begin
						state <= S_WAIT_REL;
					end
				end
				S_WAIT_REL: begin
					// stale words skip the done strobe
					if (!i_mem_ack) begin
						state <= (stale || i_kill) ? S_IDLE : S_DONE;
					end
				end
				default: begin
					if (!i_stall || i_kill) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	// address and pc4 latched at issue, data at the ack rise
	always_ff @(posedge i_clk) begin
		if (issue) begin
			word_q.pc  <= i_pc;
			word_q.pc4 <= i_pc4;
		end
		if (state == S_WAIT_ACK && i_mem_ack) begin
			word_q.instr <= i_mem_rdata;
		end
	end

	assign o_mem_req  = (state == S_WAIT_ACK);
	assign o_mem_addr = word_q.pc;
	assign o_done     = (state == S_DONE) && !i_stall && !i_kill;
	assign o_word     = word_q;

endmodule

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
/*
 * instruction set subset: opcodes, funct codes, field positions,
 * word width and reset vector
 */
`default_nettype none

package isa_pkg;

	// ==============================
	// word and field layout
	// ==============================
	localparam int INSTR_W = 32;
	localparam int OP_LSB  = 26;
	localparam int OP_W    = 6;
	localparam int FN_W    = 6;
	localparam int IDX_W   = 26;
	localparam int IMM_W   = 16;

	// byte distance between consecutive instructions
	localparam logic [31:0] PC_STEP = 32'd4;

	// first fetch address after reset
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// ==============================
	// opcodes and funct codes
	// ==============================
	localparam logic [OP_W-1:0] OP_RTYPE = 6'h00;
	localparam logic [OP_W-1:0] OP_J     = 6'h02;
	localparam logic [OP_W-1:0] OP_JAL   = 6'h03;
	localparam logic [OP_W-1:0] OP_BEQ   = 6'h04;

	// jr lives under the r-type opcode
	localparam logic [FN_W-1:0] FN_JR = 6'h08;

	typedef logic [INSTR_W-1:0] instr_t;

endpackage

`default_nettype wire

// ==== verilog/pc_gen.sv ====
/*
 * PC register with PC+4 adder and next-PC select
 */
`timescale 1ns/1ps
`default_nettype none

module pc_gen
	import isa_pkg::*, fetch_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_nrst,
	input  logic        i_advance,
	input  redirect_t   i_redirect,
	output logic [31:0] o_pc,
	output logic [31:0] o_pc4
);

	logic [31:0] pc;
	logic [31:0] pc4;
	logic [31:0] next_pc;

	// sequential successor
	assign pc4 = pc + PC_STEP;

	// ==============================
	// next-PC select
	// ==============================
	// a redirect wins over a plain advance
	always_comb begin
		if (i_redirect.valid) begin
			next_pc = i_redirect.target;
		end else if (i_advance) begin
			next_pc = pc4;
		end else begin
			next_pc = pc;
		end
	end

	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			pc <= RESET_PC;
		end else begin
			pc <= next_pc;
		end
	end

	assign o_pc  = pc;
	assign o_pc4 = pc4;

endmodule

`default_nettype wire

// ==== verilog/stage_reg.sv ====
/*
 * valid-tagged pipeline register with hold and flush
 */
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     i_clk,
	input  logic     i_nrst,
	input  logic     i_load,
	input  logic     i_hold,
	input  logic     i_flush,
	input  payload_t i_data,
	output logic     o_valid,
	output payload_t o_data
);

	logic     valid;
	payload_t data;

	// flush beats hold, hold beats load
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			valid <= 1'b0;
		end else if (i_flush) begin
			valid <= 1'b0;
		end else if (!i_hold) begin
			valid <= i_load;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_load && !i_hold) begin
			data <= i_data;
		end
	end

	assign o_valid = valid;
	assign o_data  = data;

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/isa_pkg.sv
verilog/fetch_pkg.sv
verilog/pc_gen.sv
verilog/imem_req.sv
verilog/stage_reg.sv
verilog/ctrl_decode.sv
verilog/fetch_top.sv
sim/fetch_checker.sv
sim/tb_fetch.sv
